// ==== core_controller.f ====
+incdir+logic
logic/ctrl_pkg.sv
logic/ctrl_fsm.sv
logic/hazard_unit.sv
logic/forward_unit.sv
logic/core_controller.sv
verification/core_controller_tb.sv

// ==== logic/core_controller.sv ====
//////////////////////////////
// core controller top
// ties the fsm to the hazard and forwarding logic
//////////////////////////////

`timescale 1ns/1ns

`include "ctrl_params.svh"

module core_controller
(
  input  logic                     clk,
  input  logic                     rst_n,
  // fsm control
  input  logic                     fetch_enable_i,
  input  logic                     instr_valid_i,
  input  logic                     branch_taken_ex_i,
  input  ctrl_pkg::jump_kind_e     jump_in_dec_i,
  input  logic                     exc_req_i,
  input  logic                     eret_insn_i,
  input  logic                     pipe_flush_i,
  input  logic                     illegal_insn_i,
  input  logic                     id_valid_i,
  input  logic                     ex_valid_i,
  input  logic                     wb_valid_i,
  // write-back paths and match flags
  input  logic                     data_req_ex_i,
  input  logic                     data_misaligned_i,
  input  logic                     regfile_we_ex_i,
  input  logic                     regfile_we_wb_i,
  input  logic                     regfile_alu_we_fw_i,
  input  logic [`CTRL_NUM_OPS-1:0] ex_match_i,
  input  logic [`CTRL_NUM_OPS-1:0] wb_match_i,
  input  logic [`CTRL_NUM_OPS-1:0] alu_match_i,
  // fetch and exception control
  output logic                     core_busy_o,
  output logic                     is_decoding_o,
  output logic                     instr_req_o,
  output logic                     pc_set_o,
  output ctrl_pkg::pc_mux_e        pc_mux_o,
  output logic                     exc_ack_o,
  output logic                     exc_save_id_o,
  output logic                     exc_restore_id_o,
  output logic                     halt_if_o,
  output logic                     halt_id_o,
  // stalls and operand selects
  output logic                     deassert_we_o,
  output logic                     load_stall_o,
  output logic                     jr_stall_o,
  output logic                     misaligned_stall_o,
  output ctrl_pkg::fw_sel_e        operand_a_fw_sel_o,
  output ctrl_pkg::fw_sel_e        operand_b_fw_sel_o,
  output ctrl_pkg::fw_sel_e        operand_c_fw_sel_o
);

  import ctrl_pkg::*;

  //////////////////////////////
  // control fsm
  //////////////////////////////
  ctrl_fsm u_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .exc_req_i         (exc_req_i),
    .eret_insn_i       (eret_insn_i),
    .pipe_flush_i      (pipe_flush_i),
    // jalr waits here until its source is written
    .jr_stall_i        (jr_stall_o),
    .id_valid_i        (id_valid_i),
    .ex_valid_i        (ex_valid_i),
    .wb_valid_i        (wb_valid_i),
    .core_busy_o       (core_busy_o),
    .is_decoding_o     (is_decoding_o),
    .instr_req_o       (instr_req_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .exc_ack_o         (exc_ack_o),
    .exc_save_id_o     (exc_save_id_o),
    .exc_restore_id_o  (exc_restore_id_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o)
  );

  //////////////////////////////
  // stalls and forwarding
  //////////////////////////////
  hazard_unit u_hazard (
    .is_decoding_i       (is_decoding_o),
    .illegal_insn_i      (illegal_insn_i),
    .data_req_ex_i       (data_req_ex_i),
    .jump_in_dec_i       (jump_in_dec_i),
    .regfile_we_ex_i     (regfile_we_ex_i),
    .regfile_we_wb_i     (regfile_we_wb_i),
    .regfile_alu_we_fw_i (regfile_alu_we_fw_i),
    .ex_match_i          (ex_match_i),
    .wb_match_i          (wb_match_i),
    .alu_match_i         (alu_match_i),
    .load_stall_o        (load_stall_o),
    .jr_stall_o          (jr_stall_o),
    .deassert_we_o       (deassert_we_o)
  );

  forward_unit u_forward (
    .regfile_we_wb_i     (regfile_we_wb_i),
    .regfile_alu_we_fw_i (regfile_alu_we_fw_i),
    .wb_match_i          (wb_match_i),
    .alu_match_i         (alu_match_i),
    .data_misaligned_i   (data_misaligned_i),
    .operand_a_fw_sel_o  (operand_a_fw_sel_o),
    .operand_b_fw_sel_o  (operand_b_fw_sel_o),
    .operand_c_fw_sel_o  (operand_c_fw_sel_o)
  );

  // lsu holds the pipeline while the second half of a misaligned access issues
  assign misaligned_stall_o = data_misaligned_i;

endmodule

// ==== logic/ctrl_fsm.sv ====
//////////////////////////////
// main control fsm
// boot, decode, flush and sleep sequencing
// with pc redirection and pipeline halts
//////////////////////////////

`timescale 1ns/1ns

module ctrl_fsm
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_enable_i,
  input  logic                 instr_valid_i,
  input  logic                 branch_taken_ex_i,
  input  ctrl_pkg::jump_kind_e jump_in_dec_i,
  input  logic                 exc_req_i,
  input  logic                 eret_insn_i,
  input  logic                 pipe_flush_i,
  input  logic                 jr_stall_i,
  input  logic                 id_valid_i,
  input  logic                 ex_valid_i,
  input  logic                 wb_valid_i,
  output logic                 core_busy_o,
  output logic                 is_decoding_o,
  output logic                 instr_req_o,
  output logic                 pc_set_o,
  output ctrl_pkg::pc_mux_e    pc_mux_o,
  output logic                 exc_ack_o,
  output logic                 exc_save_id_o,
  output logic                 exc_restore_id_o,
  output logic                 halt_if_o,
  output logic                 halt_id_o
);

  import ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // set once a jump has redirected the pc, cleared when id moves on
  logic jump_done_q;
  logic jump_done_d;

  //////////////////////////////
  // next state and outputs
  //////////////////////////////
  always_comb
  begin
    // defaults for a running core
    state_d          = state_q;
    jump_done_d      = jump_done_q;
    instr_req_o      = 1'b1;
    core_busy_o      = 1'b1;
    is_decoding_o    = 1'b0;
    pc_set_o         = 1'b0;
    pc_mux_o         = PC_BOOT;
    exc_ack_o        = 1'b0;
    exc_save_id_o    = 1'b0;
    exc_restore_id_o = 1'b0;
    halt_if_o        = 1'b0;
    halt_id_o        = 1'b0;

    unique case (state_q)
      // idle after reset until fetching is enabled
      RESET:
      begin
        instr_req_o = 1'b0;
        core_busy_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // load the boot address into the fetch pc, single cycle
      BOOT_SET:
      begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      // core idle, woken by fetch enable or a pending exception
      SLEEP:
      begin
        instr_req_o = 1'b0;
        core_busy_o = 1'b0;
        if (fetch_enable_i || exc_req_i)
          state_d = FIRST_FETCH;
      end

      // wait for the first instruction to reach id
      FIRST_FETCH:
      begin
        if (id_valid_i)
          state_d = DECODE;

        // exception arriving while waking up
        if (exc_req_i)
        begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          exc_save_id_o = 1'b1;
        end
      end

      DECODE:
      begin
        // only decode when no taken branch sits in ex
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;

          if (jump_in_dec_i == BRANCH_JAL || jump_in_dec_i == BRANCH_JALR)
          begin
            // target is known in decode, redirect once
            pc_mux_o = PC_JUMP;
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            pc_set_o      = 1'b1;
            pc_mux_o      = PC_EXCEPTION;
            exc_ack_o     = 1'b1;
            // keep the current instruction out of ex
            halt_id_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end

          // return from exception
          if (eret_insn_i)
          begin
            pc_set_o         = 1'b1;
            pc_mux_o         = PC_ERET;
            exc_restore_id_o = 1'b1;
          end

          // wfi, or eret back into sleep
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i))
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // taken branch in ex wins over anything in id
        if (branch_taken_ex_i)
        begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_BRANCH;
          is_decoding_o = 1'b0;
        end
      end

      // drain ex
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        if (ex_valid_i)
          state_d = FLUSH_WB;
      end

      // drain wb, then sleep or resume
      FLUSH_WB:
      begin
        if (!fetch_enable_i)
        begin
          halt_if_o = 1'b1;
          if (wb_valid_i)
            state_d = SLEEP;
        end
        else if (id_valid_i)
        begin
          state_d = DECODE;
        end
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////
  // state registers
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      jump_done_q <= jump_done_d & ~id_valid_i;
    end
  end

  // ex cannot resolve two taken branches back to back without prediction in if
  assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |=> !branch_taken_ex_i)
    else $error("taken branches in consecutive cycles");

endmodule

// ==== logic/ctrl_params.svh ====
//////////////////////////////
// controller encoding widths
// shared sizes for the fsm, hazard and forwarding logic
//////////////////////////////

`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// controller state register width
`define CTRL_STATE_W  3

// pc source select towards the fetch stage
`define CTRL_PC_MUX_W 3

// operand forwarding select
`define CTRL_FW_SEL_W 2

// jump class code from the decoder
`define CTRL_JUMP_W   2

// source operands a, b and c; match flags use these bit positions
`define CTRL_NUM_OPS  3
`define CTRL_OP_A     0
`define CTRL_OP_B     1

`endif

// ==== logic/ctrl_pkg.sv ====
//////////////////////////////
// controller type package
// state, pc source, forwarding and jump encodings
//////////////////////////////

`include "ctrl_params.svh"

package ctrl_pkg;

  // main controller states
  typedef enum logic [`CTRL_STATE_W-1:0] {
    RESET       = 3'd0,
    BOOT_SET    = 3'd1,
    SLEEP       = 3'd2,
    FIRST_FETCH = 3'd3,
    DECODE      = 3'd4,
    FLUSH_EX    = 3'd5,
    FLUSH_WB    = 3'd6
  } ctrl_state_e;

  // pc source for the fetch stage
  // code 3'b001 is the sequential pc, never selected from here
  typedef enum logic [`CTRL_PC_MUX_W-1:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_e;

  // operand source in the id stage
  typedef enum logic [`CTRL_FW_SEL_W-1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // jump class of the instruction in decode
  typedef enum logic [`CTRL_JUMP_W-1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_kind_e;

endpackage

// ==== logic/forward_unit.sv ====
//////////////////////////////
// operand forwarding
// per-operand source select for a, b and c
//////////////////////////////

`timescale 1ns/1ns

`include "ctrl_params.svh"

module forward_unit
(
  input  logic                     regfile_we_wb_i,
  input  logic                     regfile_alu_we_fw_i,
  input  logic [`CTRL_NUM_OPS-1:0] wb_match_i,
  input  logic [`CTRL_NUM_OPS-1:0] alu_match_i,
  input  logic                     data_misaligned_i,
  output ctrl_pkg::fw_sel_e        operand_a_fw_sel_o,
  output ctrl_pkg::fw_sel_e        operand_b_fw_sel_o,
  output ctrl_pkg::fw_sel_e        operand_c_fw_sel_o
);

  import ctrl_pkg::*;

  // select per operand, index matches the match flag bits
  fw_sel_e fw_sel [`CTRL_NUM_OPS];

  always_comb
  begin
    for (int i = 0; i < `CTRL_NUM_OPS; i++)
    begin
      // the alu result is younger than wb, so it has priority
      if (regfile_alu_we_fw_i && alu_match_i[i])
        fw_sel[i] = SEL_FW_EX;
      else if (regfile_we_wb_i && wb_match_i[i])
        fw_sel[i] = SEL_FW_WB;
      else
        fw_sel[i] = SEL_REGFILE;
    end

    // second half of a misaligned access reuses the address from ex
    if (data_misaligned_i)
    begin
      fw_sel[`CTRL_OP_A] = SEL_FW_EX;
      fw_sel[`CTRL_OP_B] = SEL_REGFILE;
    end
  end

  assign operand_a_fw_sel_o = fw_sel[0];
  assign operand_b_fw_sel_o = fw_sel[1];
  assign operand_c_fw_sel_o = fw_sel[2];

  // the id operand mux only decodes three sources
  always_comb
  begin
    assert final (operand_a_fw_sel_o inside {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB} &&
                  operand_b_fw_sel_o inside {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB} &&
                  operand_c_fw_sel_o inside {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB})
      else $error("forwarding select out of range");
  end

endmodule

// ==== logic/hazard_unit.sv ====
//////////////////////////////
// hazard detection
// load-use and jump-register stalls, write-enable kill
//////////////////////////////

`timescale 1ns/1ns

`include "ctrl_params.svh"

module hazard_unit
(
  input  logic                     is_decoding_i,
  input  logic                     illegal_insn_i,
  input  logic                     data_req_ex_i,
  input  ctrl_pkg::jump_kind_e     jump_in_dec_i,
  input  logic                     regfile_we_ex_i,
  input  logic                     regfile_we_wb_i,
  input  logic                     regfile_alu_we_fw_i,
  input  logic [`CTRL_NUM_OPS-1:0] ex_match_i,
  input  logic [`CTRL_NUM_OPS-1:0] wb_match_i,
  input  logic [`CTRL_NUM_OPS-1:0] alu_match_i,
  output logic                     load_stall_o,
  output logic                     jr_stall_o,
  output logic                     deassert_we_o
);

  import ctrl_pkg::*;

  // operand a of a jalr is still in flight on one of the write paths
  logic rs1_pending;

  // load in ex writing any source of the id instruction
  assign load_stall_o = data_req_ex_i & regfile_we_ex_i & (|ex_match_i);

  assign rs1_pending = (regfile_we_wb_i     & wb_match_i[`CTRL_OP_A]) |
                       (regfile_we_ex_i     & ex_match_i[`CTRL_OP_A]) |
                       (regfile_alu_we_fw_i & alu_match_i[`CTRL_OP_A]);

  // jalr target comes from operand a, wait until it is written back
  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) & rs1_pending;

  // kill register writes of anything that must not retire now
  // fsm state does not matter, outside decode the kill is set anyway
  assign deassert_we_o = ~is_decoding_i | illegal_insn_i | load_stall_o | jr_stall_o;

  // a stalled instruction must never write the register file
  always_comb
  begin
    assert final (!(load_stall_o || jr_stall_o) || deassert_we_o)
      else $error("stall without write-enable kill");
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the core controller testbench with verilator
set -e

cd "$(dirname "$0")"

TOP=core_controller_tb
LOG=sim.log

verilator --binary --timing --assert \
  --timescale 1ns/1ns \
  --top-module "$TOP" \
  -f core_controller.f \
  -o "V$TOP"

./obj_dir/"V$TOP" > "$LOG" 2>&1
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi

echo "simulation passed"

// ==== verification/core_controller_tb.sv ====
//////////////////////////////
// core controller testbench
// boot, forwarding, hazards, jumps,
// exceptions, flush and sleep
//////////////////////////////

`timescale 1ns/1ns

`include "ctrl_params.svh"

module core_controller_tb;

  import ctrl_pkg::*;

  localparam int          CLK_PERIOD   = 10;
  localparam int          RESET_CYCLES = 3;
  localparam int          FWD_ITERS    = 200;
  localparam int          HAZ_ITERS    = 100;
  localparam int          SLEEP_LIMIT  = 8;
  localparam int unsigned SEED         = 32'hce1be879;
  // random loops plus the fixed boot, jump, exception and flush sequences
  localparam int          TEST_CYCLES  = RESET_CYCLES + FWD_ITERS + HAZ_ITERS + SLEEP_LIMIT + 40;
  localparam int          TIMEOUT_NS   = (TEST_CYCLES + 100) * CLK_PERIOD;

  logic                     clk;
  logic                     rst_n;
  logic                     fetch_enable_i;
  logic                     instr_valid_i;
  logic                     branch_taken_ex_i;
  jump_kind_e               jump_in_dec_i;
  logic                     exc_req_i;
  logic                     eret_insn_i;
  logic                     pipe_flush_i;
  logic                     illegal_insn_i;
  logic                     id_valid_i;
  logic                     ex_valid_i;
  logic                     wb_valid_i;
  logic                     data_req_ex_i;
  logic                     data_misaligned_i;
  logic                     regfile_we_ex_i;
  logic                     regfile_we_wb_i;
  logic                     regfile_alu_we_fw_i;
  logic [`CTRL_NUM_OPS-1:0] ex_match_i;
  logic [`CTRL_NUM_OPS-1:0] wb_match_i;
  logic [`CTRL_NUM_OPS-1:0] alu_match_i;
  logic                     core_busy_o;
  logic                     is_decoding_o;
  logic                     instr_req_o;
  logic                     pc_set_o;
  pc_mux_e                  pc_mux_o;
  logic                     exc_ack_o;
  logic                     exc_save_id_o;
  logic                     exc_restore_id_o;
  logic                     halt_if_o;
  logic                     halt_id_o;
  logic                     deassert_we_o;
  logic                     load_stall_o;
  logic                     jr_stall_o;
  logic                     misaligned_stall_o;
  fw_sel_e                  operand_a_fw_sel_o;
  fw_sel_e                  operand_b_fw_sel_o;
  fw_sel_e                  operand_c_fw_sel_o;

  // bookkeeping
  int          check_count;
  int          test_errors;
  int          total_errors;
  int          tests_run;
  int          tests_failed;
  int          wait_cycles;
  string       test_name;
  int unsigned rnd;

  // expected hazard outputs
  logic exp_load;
  logic exp_jr;
  logic exp_kill;

  core_controller DUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // reporting
  //////////////////////////////
  task automatic report_mismatch(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
    $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
    test_errors++;
    total_errors++;
  endtask

  task automatic report_failure(input string what);
    $display("failure at %0t ns in test %s: %s", $time, test_name, what);
    test_errors++;
    total_errors++;
  endtask

  task automatic expect_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    check_count++;
    assert (actual === expected)
    else
      report_mismatch(name, actual, expected);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    tests_run++;
  endtask

  task automatic finish_test;
    if (test_errors != 0)
      tests_failed++;
    $display("test %-12s %s, %0d errors", test_name, test_errors == 0 ? "ok" : "failed",
             test_errors);
  endtask

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////
  // step to just after the rising edge, where inputs change
  task automatic next_cycle;
    @(posedge clk);
    #1;
  endtask

  // outputs are settled halfway through the cycle
  task automatic mid_cycle;
    #(CLK_PERIOD / 2 - 1);
  endtask

  // everything except reset and fetch enable back to idle
  task automatic quiet_inputs;
    instr_valid_i       = 1'b0;
    branch_taken_ex_i   = 1'b0;
    jump_in_dec_i       = BRANCH_NONE;
    exc_req_i           = 1'b0;
    eret_insn_i         = 1'b0;
    pipe_flush_i        = 1'b0;
    illegal_insn_i      = 1'b0;
    id_valid_i          = 1'b0;
    ex_valid_i          = 1'b0;
    wb_valid_i          = 1'b0;
    data_req_ex_i       = 1'b0;
    data_misaligned_i   = 1'b0;
    regfile_we_ex_i     = 1'b0;
    regfile_we_wb_i     = 1'b0;
    regfile_alu_we_fw_i = 1'b0;
    ex_match_i          = '0;
    wb_match_i          = '0;
    alu_match_i         = '0;
  endtask

  task automatic expect_idle;
    expect_value("instr_req_o", 32'(instr_req_o), 0);
    expect_value("core_busy_o", 32'(core_busy_o), 0);
    expect_value("pc_set_o", 32'(pc_set_o), 0);
  endtask

  // misaligned second half overrides a and b, otherwise alu beats wb
  function automatic fw_sel_e fw_sel_model(input int op);
    if (data_misaligned_i && op == 0)
      return SEL_FW_EX;
    if (data_misaligned_i && op == 1)
      return SEL_REGFILE;
    if (regfile_alu_we_fw_i && alu_match_i[op])
      return SEL_FW_EX;
    if (regfile_we_wb_i && wb_match_i[op])
      return SEL_FW_WB;
    return SEL_REGFILE;
  endfunction

  //////////////////////////////
  // concurrent checks
  //////////////////////////////
  assert property (@(posedge clk) disable iff (!rst_n)
    misaligned_stall_o == data_misaligned_i)
    else report_mismatch("misaligned_stall_o", 32'($sampled(misaligned_stall_o)),
                         32'($sampled(data_misaligned_i)));

  // taken branch in ex always redirects and kills decode
  assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |-> pc_set_o && pc_mux_o == PC_BRANCH && !is_decoding_o)
    else report_failure("taken branch did not redirect the pc to the branch target");

  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the tests did not complete", TIMEOUT_NS);
    $display("Finished with errors");
    $finish;
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial
  begin
    rnd            = $urandom(SEED);
    rst_n          = 1'b0;
    fetch_enable_i = 1'b0;
    quiet_inputs();

    // reset held over three rising edges, then boot
    start_test("boot");
    repeat (RESET_CYCLES - 1)
    begin
      next_cycle();
      mid_cycle();
      expect_idle();
    end
    next_cycle();
    rst_n = 1'b1;
    mid_cycle();
    expect_idle();
    next_cycle();
    fetch_enable_i = 1'b1;
    mid_cycle();
    expect_idle();
    // one cycle of boot pc load
    next_cycle();
    mid_cycle();
    expect_value("pc_set_o", 32'(pc_set_o), 1);
    expect_value("pc_mux_o", 32'(pc_mux_o), 32'(PC_BOOT));
    expect_value("core_busy_o", 32'(core_busy_o), 1);
    // first fetch, waiting for id
    next_cycle();
    id_valid_i = 1'b1;
    mid_cycle();
    expect_value("pc_set_o", 32'(pc_set_o), 0);
    expect_value("core_busy_o", 32'(core_busy_o), 1);
    next_cycle();
    id_valid_i    = 1'b0;
    instr_valid_i = 1'b1;
    mid_cycle();
    expect_value("is_decoding_o", 32'(is_decoding_o), 1);
    finish_test();

    start_test("forwarding");
    for (int i = 0; i < FWD_ITERS; i++)
    begin
      next_cycle();
      quiet_inputs();
      rnd                 = $urandom();
      regfile_we_wb_i     = rnd[0];
      regfile_alu_we_fw_i = rnd[1];
      wb_match_i          = rnd[4:2];
      alu_match_i         = rnd[7:5];
      data_misaligned_i   = rnd[8];
      mid_cycle();
      expect_value("operand_a_fw_sel_o", 32'(operand_a_fw_sel_o), 32'(fw_sel_model(0)));
      expect_value("operand_b_fw_sel_o", 32'(operand_b_fw_sel_o), 32'(fw_sel_model(1)));
      expect_value("operand_c_fw_sel_o", 32'(operand_c_fw_sel_o), 32'(fw_sel_model(2)));
    end
    finish_test();

    // fsm sits in decode, id_valid keeps the jump flag clear
    start_test("hazards");
    for (int i = 0; i < HAZ_ITERS; i++)
    begin
      next_cycle();
      quiet_inputs();
      rnd                 = $urandom();
      instr_valid_i       = rnd[0];
      illegal_insn_i      = rnd[1];
      data_req_ex_i       = rnd[2];
      regfile_we_ex_i     = rnd[3];
      regfile_we_wb_i     = rnd[4];
      regfile_alu_we_fw_i = rnd[5];
      ex_match_i          = rnd[8:6];
      wb_match_i          = rnd[11:9];
      alu_match_i         = rnd[14:12];
      jump_in_dec_i       = jump_kind_e'(rnd[16:15]);
      id_valid_i          = 1'b1;
      mid_cycle();
      exp_load = data_req_ex_i && regfile_we_ex_i && (ex_match_i != '0);
      exp_jr   = (jump_in_dec_i == BRANCH_JALR) &&
                 ((regfile_we_wb_i && wb_match_i[0]) ||
                  (regfile_we_ex_i && ex_match_i[0]) ||
                  (regfile_alu_we_fw_i && alu_match_i[0]));
      exp_kill = !instr_valid_i || illegal_insn_i || exp_load || exp_jr;
      expect_value("is_decoding_o", 32'(is_decoding_o), 32'(instr_valid_i));
      expect_value("load_stall_o", 32'(load_stall_o), 32'(exp_load));
      expect_value("jr_stall_o", 32'(jr_stall_o), 32'(exp_jr));
      expect_value("deassert_we_o", 32'(deassert_we_o), 32'(exp_kill));
    end
    finish_test();

    start_test("jumps");
    next_cycle();
    quiet_inputs();
    id_valid_i = 1'b1;
    next_cycle();
    id_valid_i    = 1'b0;
    instr_valid_i = 1'b1;
    jump_in_dec_i = BRANCH_JAL;
    mid_cycle();
    expect_value("pc_set_o", 32'(pc_set_o), 1);
    expect_value("pc_mux_o", 32'(pc_mux_o), 32'(PC_JUMP));
    // same jal still in id, no second redirect
    next_cycle();
    mid_cycle();
    expect_value("pc_set_o", 32'(pc_set_o), 0);
    next_cycle();
    id_valid_i = 1'b1;
    mid_cycle();
    expect_value("pc_set_o", 32'(pc_set_o), 0);
    // jalr with operand a pending in wb
    next_cycle();
    id_valid_i      = 1'b0;
    jump_in_dec_i   = BRANCH_JALR;
    regfile_we_wb_i = 1'b1;
    wb_match_i      = 3'b001;
    mid_cycle();
    expect_value("jr_stall_o", 32'(jr_stall_o), 1);
    expect_value("pc_set_o", 32'(pc_set_o), 0);
    expect_value("deassert_we_o", 32'(deassert_we_o), 1);
    next_cycle();
    regfile_we_wb_i = 1'b0;
    wb_match_i      = '0;
    mid_cycle();
    expect_value("jr_stall_o", 32'(jr_stall_o), 0);
    expect_value("pc_set_o", 32'(pc_set_o), 1);
    expect_value("pc_mux_o", 32'(pc_mux_o), 32'(PC_JUMP));
    // taken branch for a single cycle
    next_cycle();
    jump_in_dec_i     = BRANCH_NONE;
    id_valid_i        = 1'b1;
    branch_taken_ex_i = 1'b1;
    mid_cycle();
    expect_value("pc_set_o", 32'(pc_set_o), 1);
    expect_value("pc_mux_o", 32'(pc_mux_o), 32'(PC_BRANCH));
    expect_value("is_decoding_o", 32'(is_decoding_o), 0);
    next_cycle();
    branch_taken_ex_i = 1'b0;
    id_valid_i        = 1'b0;
    mid_cycle();
    expect_value("pc_set_o", 32'(pc_set_o), 0);
    expect_value("is_decoding_o", 32'(is_decoding_o), 1);
    finish_test();

    start_test("exceptions");
    next_cycle();
    quiet_inputs();
    instr_valid_i = 1'b1;
    exc_req_i     = 1'b1;
    mid_cycle();
    expect_value("pc_set_o", 32'(pc_set_o), 1);
    expect_value("pc_mux_o", 32'(pc_mux_o), 32'(PC_EXCEPTION));
    expect_value("exc_ack_o", 32'(exc_ack_o), 1);
    expect_value("halt_id_o", 32'(halt_id_o), 1);
    expect_value("exc_save_id_o", 32'(exc_save_id_o), 1);
    next_cycle();
    exc_req_i   = 1'b0;
    eret_insn_i = 1'b1;
    mid_cycle();
    expect_value("pc_set_o", 32'(pc_set_o), 1);
    expect_value("pc_mux_o", 32'(pc_mux_o), 32'(PC_ERET));
    expect_value("exc_restore_id_o", 32'(exc_restore_id_o), 1);
    expect_value("halt_if_o", 32'(halt_if_o), 0);
    next_cycle();
    eret_insn_i = 1'b0;
    mid_cycle();
    expect_value("pc_set_o", 32'(pc_set_o), 0);
    finish_test();

    // wfi with fetch disabled drains ex and wb, then sleeps
    start_test("flush_sleep");
    next_cycle();
    quiet_inputs();
    fetch_enable_i = 1'b0;
    instr_valid_i  = 1'b1;
    pipe_flush_i   = 1'b1;
    mid_cycle();
    expect_value("halt_if_o", 32'(halt_if_o), 1);
    expect_value("halt_id_o", 32'(halt_id_o), 1);
    next_cycle();
    quiet_inputs();
    mid_cycle();
    expect_value("halt_if_o", 32'(halt_if_o), 1);
    next_cycle();
    ex_valid_i = 1'b1;
    mid_cycle();
    expect_value("halt_if_o", 32'(halt_if_o), 1);
    next_cycle();
    ex_valid_i = 1'b0;
    mid_cycle();
    expect_value("halt_if_o", 32'(halt_if_o), 1);
    next_cycle();
    wb_valid_i = 1'b1;
    mid_cycle();
    expect_value("halt_if_o", 32'(halt_if_o), 1);
    wait_cycles = 0;
    do
    begin
      next_cycle();
      wb_valid_i = 1'b0;
      mid_cycle();
      wait_cycles++;
    end
    while (core_busy_o && wait_cycles < SLEEP_LIMIT);
    if (core_busy_o)
      report_failure("core stayed busy after ex and wb had drained");
    expect_value("core_busy_o", 32'(core_busy_o), 0);
    expect_value("instr_req_o", 32'(instr_req_o), 0);
    // pending exception wakes the core
    next_cycle();
    exc_req_i = 1'b1;
    mid_cycle();
    expect_value("core_busy_o", 32'(core_busy_o), 0);
    next_cycle();
    mid_cycle();
    expect_value("core_busy_o", 32'(core_busy_o), 1);
    expect_value("instr_req_o", 32'(instr_req_o), 1);
    expect_value("pc_mux_o", 32'(pc_mux_o), 32'(PC_EXCEPTION));
    next_cycle();
    exc_req_i = 1'b0;
    finish_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
             check_count, total_errors);
    if (total_errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule
